/* Makefile */
# Verilator build, run and lint for the masked butterfly testbench

VERILATOR  ?= verilator
TOP        ?= ntt_masked_bf_tb
FILELIST   ?= verilog.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# The log decides pass or fail
run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "^Regression passed$$" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* rtl/ntt_bf_cfg.sv */
// Mode configuration register
`timescale 1ns/1ps
`default_nettype none

module ntt_bf_cfg
    import ntt_ctrl_pkg::*;
(
    input  wire   clk,
    input  wire   reset_n,
    input  wire   cfg_req_i,
    input  mode_t cfg_mode_i,
    output logic  cfg_ack_o,
    input  wire   busy_i,
    input  wire   valid_i,
    output mode_t mode_o
);

    cfg_state_t state, state_next;
    mode_t      mode_q;
    logic       write_en;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state  <= CFG_IDLE;
            mode_q <= MODE_INTT;
        end else begin
            state <= state_next;
            if (write_en) begin
                mode_q <= cfg_mode_i;
            end
        end
    end

    // Write only once the datapath has drained
    always_comb begin
        state_next = state;
        write_en   = 1'b0;
        unique case (state)
            CFG_IDLE, CFG_WAIT_EMPTY: begin
                if (cfg_req_i) begin
                    if (busy_i) begin
                        state_next = CFG_WAIT_EMPTY;
                    end else begin
                        write_en   = 1'b1;
                        state_next = CFG_ACK;
                    end
                end
            end
            CFG_ACK: begin
                if (!cfg_req_i) begin
                    state_next = CFG_IDLE;
                end
            end
            default: state_next = CFG_IDLE;
        endcase
    end

    assign cfg_ack_o = (state == CFG_ACK);
    assign mode_o    = mode_q;

    // No new data while a mode change is pending
    assert property (@(posedge clk) disable iff (!reset_n) cfg_req_i |-> !valid_i);

    assert property (@(posedge clk) disable iff (!reset_n) $rose(cfg_ack_o) |-> cfg_req_i);

endmodule

`default_nettype wire

/* rtl/ntt_ctrl_pkg.sv */
// Mode and configuration control types
`default_nettype none

package ntt_ctrl_pkg;

    // Operating mode of the butterfly pair
    typedef enum logic {
        MODE_INTT = 1'b0,
        MODE_PWM  = 1'b1
    } mode_t;

    // Four-phase configuration write
    typedef enum logic [1:0] {
        CFG_IDLE       = 2'd0,
        CFG_WAIT_EMPTY = 2'd1,
        CFG_ACK        = 2'd2
    } cfg_state_t;

endpackage

`default_nettype wire

/* rtl/ntt_defines.svh */
// NTT butterfly constants
`ifndef NTT_DEFINES_SVH
`define NTT_DEFINES_SVH

// Modulus of the signature scheme
`define NTT_Q 8380417

// Width of one residue modulo q
`define NTT_COEFF_W 23

// Cycles from butterfly operands to butterfly output shares
`define NTT_BF_LAT 3

// Cycles from valid_i to valid_o at the top level
// Butterfly stages plus the combine and halve register
`define NTT_TOTAL_LAT 4

`endif

/* rtl/ntt_masked_bf_top.sv */
// Masked INTT first stage top level
`timescale 1ns/1ps
`default_nettype none

module ntt_masked_bf_top
    import ntt_types_pkg::*;
    import ntt_ctrl_pkg::*;
(
    input  wire     clk,
    input  wire     reset_n,
    input  wire     zeroize_i,
    input  wire     cfg_req_i,
    input  mode_t   cfg_mode_i,
    output logic    cfg_ack_o,
    input  wire     valid_i,
    input  shares_t u0_i,
    input  shares_t v0_i,
    input  shares_t w0_i,
    input  shares_t u1_i,
    input  shares_t v1_i,
    input  shares_t w1_i,
    input  rnd_t    rnd_i,
    output logic    valid_o,
    output coeff_t  u20_o,
    output coeff_t  u21_o,
    output coeff_t  v20_o,
    output coeff_t  v21_o,
    output shares_t pwm0_o,
    output shares_t pwm1_o
);

    mode_t mode;
    logic  busy;

    ntt_bf_cfg i_cfg (
        .clk(clk), .reset_n(reset_n),
        .cfg_req_i(cfg_req_i), .cfg_mode_i(cfg_mode_i), .cfg_ack_o(cfg_ack_o),
        .busy_i(busy), .valid_i(valid_i), .mode_o(mode)
    );

    ntt_masked_butterfly1x2 i_bf1x2 (
        .clk(clk), .reset_n(reset_n), .zeroize_i(zeroize_i),
        .valid_i(valid_i), .mode_i(mode),
        .u0_i(u0_i), .v0_i(v0_i), .w0_i(w0_i),
        .u1_i(u1_i), .v1_i(v1_i), .w1_i(w1_i),
        .rnd_i(rnd_i), .busy_o(busy), .valid_o(valid_o),
        .u20_o(u20_o), .u21_o(u21_o), .v20_o(v20_o), .v21_o(v21_o),
        .pwm0_o(pwm0_o), .pwm1_o(pwm1_o)
    );

endmodule

`default_nettype wire

/* rtl/ntt_masked_butterfly1x2.sv */
// Masked butterfly pair with combine and halve
`timescale 1ns/1ps
`default_nettype none

`include "ntt_defines.svh"

module ntt_masked_butterfly1x2
    import ntt_types_pkg::*;
    import ntt_ctrl_pkg::*;
(
    input  wire     clk,
    input  wire     reset_n,
    input  wire     zeroize_i,
    input  wire     valid_i,
    input  mode_t   mode_i,
    input  shares_t u0_i,
    input  shares_t v0_i,
    input  shares_t w0_i,
    input  shares_t u1_i,
    input  shares_t v1_i,
    input  shares_t w1_i,
    input  rnd_t    rnd_i,
    output logic    busy_o,
    output logic    valid_o,
    output coeff_t  u20_o,
    output coeff_t  u21_o,
    output coeff_t  v20_o,
    output coeff_t  v21_o,
    output shares_t pwm0_o,
    output shares_t pwm1_o
);

    localparam int W = `NTT_COEFF_W;

    logic       bf0_valid, bf1_valid, pwm_mode;
    logic [1:0] inflight;
    shares_t    bf0_u, bf0_v, bf1_u, bf1_v;

    // Odd values get q added before halving modulo q
    function automatic coeff_t half_mod(coeff_t c);
        logic [W:0] t;
        t = c[0] ? (W+1)'({1'b0, c} + `NTT_Q) : {1'b0, c};
        return t[W:1];
    endfunction

    function automatic coeff_t unmask(shares_t s);
        return add_mod(s[W-1:0], s[2*W-1:W]);
    endfunction

    assign pwm_mode = (mode_i == MODE_PWM);

    ntt_masked_gs_butterfly i_bf0 (
        .clk(clk), .reset_n(reset_n), .zeroize_i(zeroize_i),
        .valid_i(valid_i), .mode_i(mode_i),
        .opu_i(u0_i), .opv_i(v0_i), .opw_i(w0_i),
        .rnd_a_i(rnd_i[W-1:0]), .rnd_b_i(rnd_i[2*W-1:W]),
        .valid_o(bf0_valid), .u_o(bf0_u), .v_o(bf0_v)
    );

    // Second butterfly sees the random words shifted by one
    ntt_masked_gs_butterfly i_bf1 (
        .clk(clk), .reset_n(reset_n), .zeroize_i(zeroize_i),
        .valid_i(valid_i), .mode_i(mode_i),
        .opu_i(u1_i), .opv_i(v1_i), .opw_i(w1_i),
        .rnd_a_i(rnd_i[2*W-1:W]), .rnd_b_i(rnd_i[3*W-1:2*W]),
        .valid_o(bf1_valid), .u_o(bf1_u), .v_o(bf1_v)
    );

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            inflight <= '0;
            valid_o  <= 1'b0;
            u20_o    <= '0;
            u21_o    <= '0;
            v20_o    <= '0;
            v21_o    <= '0;
            pwm0_o   <= '0;
            pwm1_o   <= '0;
        end else if (zeroize_i) begin
            inflight <= '0;
            valid_o  <= 1'b0;
            u20_o    <= '0;
            u21_o    <= '0;
            v20_o    <= '0;
            v21_o    <= '0;
            pwm0_o   <= '0;
            pwm1_o   <= '0;
        end else begin
            // Items inside the butterflies, at most three
            inflight <= inflight + 2'(valid_i) - 2'(bf0_valid);
            valid_o  <= bf0_valid;
            u20_o    <= pwm_mode ? '0 : half_mod(unmask(bf0_u));
            u21_o    <= pwm_mode ? '0 : half_mod(unmask(bf0_v));
            v20_o    <= pwm_mode ? '0 : half_mod(unmask(bf1_u));
            v21_o    <= pwm_mode ? '0 : half_mod(unmask(bf1_v));
            pwm0_o   <= bf0_u;
            pwm1_o   <= bf1_u;
        end
    end

    assign busy_o = (inflight != '0) | bf0_valid | bf1_valid | valid_o;

    assert property (@(posedge clk) disable iff (!reset_n) bf0_valid == bf1_valid);

endmodule

`default_nettype wire

/* rtl/ntt_masked_gs_butterfly.sv */
// Masked Gentleman-Sande butterfly
`timescale 1ns/1ps
`default_nettype none

`include "ntt_defines.svh"

module ntt_masked_gs_butterfly
    import ntt_types_pkg::*;
    import ntt_ctrl_pkg::*;
(
    input  wire     clk,
    input  wire     reset_n,
    input  wire     zeroize_i,
    input  wire     valid_i,
    input  mode_t   mode_i,
    input  shares_t opu_i,
    input  shares_t opv_i,
    input  shares_t opw_i,
    input  coeff_t  rnd_a_i,
    input  coeff_t  rnd_b_i,
    output logic    valid_o,
    output shares_t u_o,
    output shares_t v_o
);

    localparam int W = `NTT_COEFF_W;

    coeff_t u0, u1, v0, v1, w0, w1;

    // Stage 1 registers
    logic   s1_valid;
    coeff_t s1_sum0, s1_sum1, s1_d0, s1_d1, s1_w0, s1_w1;

    // Stage 2 registers holding the full-width cross products
    logic            s2_valid;
    coeff_t          s2_sum0, s2_sum1;
    logic [2*W-1:0]  s2_p00, s2_p01, s2_p10, s2_p11;

    // Stage 3 combinational results
    coeff_t prod0, prod1, sum0, sum1;

    assign u0 = opu_i[W-1:0];
    assign u1 = opu_i[2*W-1:W];
    assign v0 = opv_i[W-1:0];
    assign v1 = opv_i[2*W-1:W];
    assign w0 = opw_i[W-1:0];
    assign w1 = opw_i[2*W-1:W];

    // Reduce and pair the products, then re-mask both results
    assign prod0 = add_mod(coeff_t'(s2_p00 % `NTT_Q), coeff_t'(s2_p01 % `NTT_Q));
    assign prod1 = add_mod(coeff_t'(s2_p10 % `NTT_Q), coeff_t'(s2_p11 % `NTT_Q));
    assign sum0  = (mode_i == MODE_PWM) ? prod0 : s2_sum0;
    assign sum1  = (mode_i == MODE_PWM) ? prod1 : s2_sum1;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            s1_valid <= 1'b0;
            s1_sum0  <= '0;
            s1_sum1  <= '0;
            s1_d0    <= '0;
            s1_d1    <= '0;
            s1_w0    <= '0;
            s1_w1    <= '0;
            s2_valid <= 1'b0;
            s2_sum0  <= '0;
            s2_sum1  <= '0;
            s2_p00   <= '0;
            s2_p01   <= '0;
            s2_p10   <= '0;
            s2_p11   <= '0;
            valid_o  <= 1'b0;
            u_o      <= '0;
            v_o      <= '0;
        end else if (zeroize_i) begin
            s1_valid <= 1'b0;
            s1_sum0  <= '0;
            s1_sum1  <= '0;
            s1_d0    <= '0;
            s1_d1    <= '0;
            s1_w0    <= '0;
            s1_w1    <= '0;
            s2_valid <= 1'b0;
            s2_sum0  <= '0;
            s2_sum1  <= '0;
            s2_p00   <= '0;
            s2_p01   <= '0;
            s2_p10   <= '0;
            s2_p11   <= '0;
            valid_o  <= 1'b0;
            u_o      <= '0;
            v_o      <= '0;
        end else begin
            // Share-wise sum and difference; PWM multiplies u directly
            s1_valid <= valid_i;
            s1_sum0  <= add_mod(u0, v0);
            s1_sum1  <= add_mod(u1, v1);
            s1_d0    <= (mode_i == MODE_PWM) ? u0 : sub_mod(u0, v0);
            s1_d1    <= (mode_i == MODE_PWM) ? u1 : sub_mod(u1, v1);
            s1_w0    <= w0;
            s1_w1    <= w1;
            s2_valid <= s1_valid;
            s2_sum0  <= s1_sum0;
            s2_sum1  <= s1_sum1;
            s2_p00   <= s1_d0 * s1_w0;
            s2_p01   <= s1_d0 * s1_w1;
            s2_p10   <= s1_d1 * s1_w0;
            s2_p11   <= s1_d1 * s1_w1;
            valid_o  <= s2_valid;
            u_o      <= {sub_mod(sum1, rnd_b_i), add_mod(sum0, rnd_b_i)};
            v_o      <= {sub_mod(prod1, rnd_a_i), add_mod(prod0, rnd_a_i)};
        end
    end

    // Operands must already be reduced
    assert property (@(posedge clk) disable iff (!reset_n)
        valid_i |-> (u0 < `NTT_Q) && (u1 < `NTT_Q) && (v0 < `NTT_Q) &&
                    (v1 < `NTT_Q) && (w0 < `NTT_Q) && (w1 < `NTT_Q));

endmodule

`default_nettype wire

/* rtl/ntt_types_pkg.sv */
// Coefficient and share types
`default_nettype none

`include "ntt_defines.svh"

package ntt_types_pkg;

    // One residue, one share pair (share 0 in the low half), three random words
    typedef logic [`NTT_COEFF_W-1:0]   coeff_t;
    typedef logic [2*`NTT_COEFF_W-1:0] shares_t;
    typedef logic [3*`NTT_COEFF_W-1:0] rnd_t;

    // Modular add and subtract for operands already below q
    function automatic coeff_t add_mod(coeff_t a, coeff_t b);
        logic [`NTT_COEFF_W:0] s;
        s = {1'b0, a} + {1'b0, b};
        if (s >= `NTT_Q) begin
            s = s - (`NTT_COEFF_W+1)'(`NTT_Q);
        end
        return s[`NTT_COEFF_W-1:0];
    endfunction

    function automatic coeff_t sub_mod(coeff_t a, coeff_t b);
        return (a >= b) ? coeff_t'(a - b) : coeff_t'(a + `NTT_Q - b);
    endfunction

endpackage

`default_nettype wire

/* verification/bf_input.txt */
# mode u0 v0 w0 u1 v1 w1 (hex, each below q = 7fe001) repeat (decimal)
# mode 0 is INTT, mode 1 is PWM; a mode change starts a configuration write
0 000000 000000 000000 000000 000000 000000 1
0 000001 000002 000003 000004 000005 000006 1
0 7fe000 7fe000 7fe000 000001 7fe000 000002 2
0 123456 654321 0abcde 3fffff 400000 7fdfff 3
0 000002 000001 7fe000 7fe000 000000 000001 1
0 5a5a5a 25a5a5 111111 6d6d6d 0f0f0f 222222 4
0 000003 000005 1753fe 2a2a2a 2a2a2a 7a1b2c 1
1 000002 000000 000003 7fe000 000000 7fe000 2
1 123456 000000 654321 0fedcb 000000 3ffffe 3
1 7fe000 111111 000001 000000 222222 5a5a5a 1
1 3c3c3c 000000 3c3c3c 1abcde 000000 7edcba 4
0 0a0a0a 505050 303030 707070 070707 7fe000 2
0 400001 3ffffe 000002 600000 200000 5fffff 1
1 000001 000000 000001 000001 000000 7fe000 1
1 555555 000000 2aaaaa 7fe000 000000 7fe000 2
0 1f2e3d 4c5b6a 798a7b 0c1d2e 3f4a5b 6c7d0e 3
0 000000 7fe000 000001 7fe000 000000 7fe000 1
0 2b3c4d 2b3c4d 2b3c4d 5e6f70 5e6f70 5e6f70 4
1 0fffff 000000 0fffff 7fdff0 000000 7fdff0 2
0 6a6a6a 161616 5d5d5d 0d0d0d 7d7d7d 000004 2
0 3ff000 000fff 7fe000 012345 7edcba 000010 1
0 7fe000 000001 400000 000001 7fe000 3fffff 2

/* verification/ntt_masked_bf_tb.sv */
// Masked butterfly testbench
`timescale 1ns/1ps
`default_nettype none

`include "ntt_defines.svh"

module ntt_masked_bf_tb
    import ntt_types_pkg::*;
    import ntt_ctrl_pkg::*;
();

    localparam longint Q        = `NTT_Q;
    localparam longint INV2     = (`NTT_Q + 1) / 2;
    localparam int     W        = `NTT_COEFF_W;
    localparam int     LAT      = `NTT_TOTAL_LAT;
    localparam int     MAX_VEC  = 64;
    localparam int     WAIT_MAX = 64;

    // Expected plain results of one input item
    typedef struct packed {
        mode_t  mode;
        coeff_t u20, u21, v20, v21, pwm0, pwm1;
    } expect_t;

    logic    clk;
    logic    reset_n;
    logic    zeroize_i;
    logic    cfg_req_i;
    mode_t   cfg_mode_i;
    logic    cfg_ack_o;
    logic    valid_i;
    logic    valid_o;
    shares_t u0_i, v0_i, w0_i, u1_i, v1_i, w1_i;
    rnd_t    rnd_i;
    coeff_t  u20_o, u21_o, v20_o, v21_o;
    shares_t pwm0_o, pwm1_o;

    // Vectors from the data file
    mode_t  vec_mode [MAX_VEC];
    coeff_t vec_val [MAX_VEC][6];
    int     vec_rep [MAX_VEC];
    int     vec_count = 0;
    int     max_rep = 1;
    logic   loaded = 1'b0;

    expect_t        exp_q[$];
    logic [LAT-1:0] vld_hist = '0;
    logic [31:0]    rng_state = 32'hca83f630;
    mode_t          cur_mode = MODE_INTT;
    int             checks = 0;
    int             errors = 0;

    always #4 clk = ~clk;

    ntt_masked_bf_top i_dut (
        .clk(clk), .reset_n(reset_n), .zeroize_i(zeroize_i),
        .cfg_req_i(cfg_req_i), .cfg_mode_i(cfg_mode_i), .cfg_ack_o(cfg_ack_o),
        .valid_i(valid_i),
        .u0_i(u0_i), .v0_i(v0_i), .w0_i(w0_i),
        .u1_i(u1_i), .v1_i(v1_i), .w1_i(w1_i),
        .rnd_i(rnd_i), .valid_o(valid_o),
        .u20_o(u20_o), .u21_o(u21_o), .v20_o(v20_o), .v21_o(v21_o),
        .pwm0_o(pwm0_o), .pwm1_o(pwm1_o)
    );

    function automatic logic [31:0] xorshift32(logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic coeff_t rand_coeff();
        rng_state = xorshift32(rng_state);
        return coeff_t'(rng_state % `NTT_Q);
    endfunction

    function automatic coeff_t mod_q(longint x);
        longint r;
        r = x % Q;
        if (r < 0) begin
            r = r + Q;
        end
        return coeff_t'(r);
    endfunction

    function automatic coeff_t add_q(coeff_t a, coeff_t b);
        return mod_q(longint'(a) + longint'(b));
    endfunction

    function automatic coeff_t sub_q(coeff_t a, coeff_t b);
        return mod_q(longint'(a) - longint'(b));
    endfunction

    function automatic coeff_t mul_q(coeff_t a, coeff_t b);
        return mod_q(longint'(a) * longint'(b));
    endfunction

    // Division by two is a product with the inverse of 2
    function automatic coeff_t halve(coeff_t a);
        return mod_q(longint'(a) * INV2);
    endfunction

    // Share 0 is random and share 1 makes up the value
    function automatic shares_t split_shares(coeff_t x);
        coeff_t s0;
        s0 = rand_coeff();
        return {sub_q(x, s0), s0};
    endfunction

    function automatic coeff_t recombine(shares_t s);
        return add_q(s[W-1:0], s[2*W-1:W]);
    endfunction

    task automatic check_value(string name, logic [63:0] expected, logic [63:0] actual);
        checks++;
        assert (actual === expected) else begin
            $display("FAIL %s: expected %h, got %h at %0t", name, expected, actual, $time);
            errors++;
        end
    endtask

    task automatic check_true(logic cond, string what);
        checks++;
        assert (cond) else begin
            $display("Error at %0t: %s", $time, what);
            errors++;
        end
    endtask

    task automatic check_outputs_zero();
        check_value("valid_o", 0, valid_o);
        check_value("u20_o", 0, u20_o);
        check_value("u21_o", 0, u21_o);
        check_value("v20_o", 0, v20_o);
        check_value("v21_o", 0, v21_o);
        check_value("pwm0_o", 0, pwm0_o);
        check_value("pwm1_o", 0, pwm1_o);
    endtask

    task automatic compare_outputs(expect_t e);
        check_value("u20_o", e.u20, u20_o);
        check_value("u21_o", e.u21, u21_o);
        check_value("v20_o", e.v20, v20_o);
        check_value("v21_o", e.v21, v21_o);
        if (e.mode == MODE_PWM) begin
            check_value("pwm0_o share sum", e.pwm0, recombine(pwm0_o));
            check_value("pwm1_o share sum", e.pwm1, recombine(pwm1_o));
        end
    endtask

    task automatic clear_data();
        valid_i = 1'b0;
        u0_i = '0;
        v0_i = '0;
        w0_i = '0;
        u1_i = '0;
        v1_i = '0;
        w1_i = '0;
        rnd_i = '0;
    endtask

    task automatic drive_idle();
        @(posedge clk);
        #1;
        clear_data();
    endtask

    task automatic drive_item(input coeff_t u0, v0, w0, u1, v1, w1);
        expect_t e;
        @(posedge clk);
        #1;
        valid_i = 1'b1;
        u0_i = split_shares(u0);
        v0_i = split_shares(v0);
        w0_i = split_shares(w0);
        u1_i = split_shares(u1);
        v1_i = split_shares(v1);
        w1_i = split_shares(w1);
        rnd_i = {rand_coeff(), rand_coeff(), rand_coeff()};
        e = '0;
        e.mode = cur_mode;
        if (cur_mode == MODE_INTT) begin
            e.u20 = halve(add_q(u0, v0));
            e.u21 = halve(mul_q(sub_q(u0, v0), w0));
            e.v20 = halve(add_q(u1, v1));
            e.v21 = halve(mul_q(sub_q(u1, v1), w1));
        end else begin
            e.pwm0 = mul_q(u0, w0);
            e.pwm1 = mul_q(u1, w1);
        end
        exp_q.push_back(e);
    endtask

    // Four-phase write issued right after the last input
    task automatic write_mode(input mode_t m);
        int   waited;
        logic acked;
        waited = 0;
        @(posedge clk);
        #1;
        clear_data();
        cfg_mode_i = m;
        cfg_req_i = 1'b1;
        while (!cfg_ack_o && waited < WAIT_MAX) begin
            @(negedge clk);
            waited++;
        end
        acked = cfg_ack_o;
        check_true(acked, "cfg_ack_o did not rise after cfg_req_i");
        if (acked) begin
            check_value("valid_o", 0, valid_o);
        end
        @(posedge clk);
        #1;
        if (acked) begin
            check_true(exp_q.size() == 0, "cfg_ack_o rose while items were still in flight");
        end
        cfg_req_i = 1'b0;
        @(negedge clk);
        check_value("cfg_ack_o", 1, cfg_ack_o);
        @(negedge clk);
        check_value("cfg_ack_o", 0, cfg_ack_o);
        cur_mode = m;
    endtask

    task automatic wait_drained();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < WAIT_MAX) begin
            @(posedge clk);
            #1;
            n++;
        end
        check_true(exp_q.size() == 0,
                   "results still missing after the pipeline should be empty");
    endtask

    task automatic load_vectors();
        int    fd;
        int    n;
        int    m;
        int    r;
        int    a[6];
        string line;
        fd = $fopen("verification/bf_input.txt", "r");
        if (fd == 0) begin
            $display("Error: cannot open verification/bf_input.txt");
            errors++;
        end else begin
            while (!$feof(fd) && vec_count < MAX_VEC) begin
                line = "";
                n = $fgets(line, fd);
                // Comment lines do not parse and are skipped
                n = $sscanf(line, "%h %h %h %h %h %h %h %d",
                            m, a[0], a[1], a[2], a[3], a[4], a[5], r);
                if (n == 8) begin
                    vec_mode[vec_count] = mode_t'(m[0]);
                    for (int i = 0; i < 6; i++) begin
                        vec_val[vec_count][i] = coeff_t'(a[i]);
                    end
                    vec_rep[vec_count] = r;
                    if (r > max_rep) begin
                        max_rep = r;
                    end
                    vec_count++;
                end
            end
            $fclose(fd);
            check_true(vec_count > 0, "no vectors found in the data file");
        end
    endtask

    // Results are due LAT cycles after each valid input
    always @(negedge clk) begin
        if (reset_n) begin
            check_value("valid_o", vld_hist[LAT-1], valid_o);
            if (vld_hist[LAT-1] && exp_q.size() != 0) begin
                compare_outputs(exp_q.pop_front());
            end
            if (zeroize_i) begin
                vld_hist = '0;
                exp_q.delete();
            end else begin
                vld_hist = {vld_hist[LAT-2:0], valid_i};
            end
        end
    end

    initial begin
        clk = 1'b0;
        reset_n = 1'b0;
        zeroize_i = 1'b0;
        cfg_req_i = 1'b0;
        cfg_mode_i = MODE_INTT;
        clear_data();
        load_vectors();
        loaded = 1'b1;
        repeat (4) @(posedge clk);
        #1;
        reset_n = 1'b1;

        repeat (3) begin
            @(negedge clk);
            check_outputs_zero();
            check_value("cfg_ack_o", 0, cfg_ack_o);
        end

        for (int i = 0; i < vec_count; i++) begin
            if (vec_mode[i] != cur_mode) begin
                write_mode(vec_mode[i]);
            end
            for (int k = 0; k < vec_rep[i]; k++) begin
                drive_item(vec_val[i][0], vec_val[i][1], vec_val[i][2],
                           vec_val[i][3], vec_val[i][4], vec_val[i][5]);
            end
        end
        drive_idle();
        wait_drained();

        // Zeroize with three items in flight
        if (cur_mode != MODE_INTT) begin
            write_mode(MODE_INTT);
        end
        for (int i = 0; i < 3; i++) begin
            drive_item(rand_coeff(), rand_coeff(), rand_coeff(),
                       rand_coeff(), rand_coeff(), rand_coeff());
        end
        @(posedge clk);
        #1;
        clear_data();
        zeroize_i = 1'b1;
        @(posedge clk);
        #1;
        zeroize_i = 1'b0;
        repeat (6) begin
            @(negedge clk);
            check_outputs_zero();
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // Watchdog sized from the vector count and the longest repeat
    initial begin
        int limit;
        wait (loaded);
        limit = 20 * (vec_count * max_rep + 50);
        repeat (limit) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", limit);
        $display("Checks: %0d, errors: %0d", checks, errors);
        $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+rtl
rtl/ntt_types_pkg.sv
rtl/ntt_ctrl_pkg.sv
rtl/ntt_masked_gs_butterfly.sv
rtl/ntt_masked_butterfly1x2.sv
rtl/ntt_bf_cfg.sv
rtl/ntt_masked_bf_top.sv
verification/ntt_masked_bf_tb.sv
